// ==== build.f ====
+incdir+hdl
hdl/sram_pkg.sv
hdl/sram_macro.sv
hdl/axi_burst_addr.sv
hdl/axi_sram_ctrl.sv
hdl/axi_sram_top.sv
verification/tb_axi_sram.sv

// ==== hdl/axi_burst_addr.sv ====
`timescale 1ns/1ns

module axi_burst_addr #(
    parameter int DEPTH_WORDS = 4096
) (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  start,
    input  logic                                  step,
    input  sram_pkg::axi_addr_t                   cmd,
    output logic [sram_pkg::WORD_ADDR_BITS-1:0]   word_addr,
    output logic                                  last,
    output logic                                  out_of_range
);

    localparam int WA = sram_pkg::WORD_ADDR_BITS;
    localparam int LB = sram_pkg::LEN_BITS;

    logic [WA-1:0]        addr_q;
    logic [WA-1:0]        next_addr;
    logic [WA-1:0]        wrap_mask;
    logic [LB-1:0]        len_q;
    logic [LB-1:0]        beat_cnt;
    sram_pkg::axi_burst_e burst_q;

    // len+1 is a power of two for WRAP, so len is the low-bit mask
    assign wrap_mask = {{(WA-LB){1'b0}}, len_q};

    always_comb begin
        case (burst_q)
            sram_pkg::FIXED: next_addr = addr_q;
            sram_pkg::WRAP:  next_addr = (addr_q & ~wrap_mask) |
                                         ((addr_q + 1'b1) & wrap_mask);
            default:         next_addr = addr_q + 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            addr_q   <= '0;
            len_q    <= '0;
            beat_cnt <= '0;
            burst_q  <= sram_pkg::INCR;
        end else if (start) begin
            addr_q   <= cmd.addr[sram_pkg::ADDR_BITS-1:2];
            len_q    <= cmd.len;
            beat_cnt <= '0;
            burst_q  <= cmd.burst;
        end else if (step) begin
            addr_q   <= next_addr;
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign word_addr    = addr_q;
    assign last         = (beat_cnt == len_q);
    assign out_of_range = (int'(addr_q) >= DEPTH_WORDS);

    // Wrap blocks must be 2, 4, 8 or 16 beats
    a_wrap_len: assert property (@(posedge clk) disable iff (!rst)
        start && cmd.burst == sram_pkg::WRAP |-> cmd.len inside {4'd1, 4'd3, 4'd7, 4'd15});

    // Only full-word transfers are handled
    a_word_size: assert property (@(posedge clk) disable iff (!rst)
        start |-> cmd.size == sram_pkg::SIZE_WORD);

endmodule

// ==== hdl/axi_defs.svh ====
`ifndef AXI_DEFS_SVH
`define AXI_DEFS_SVH

// Channel field widths
`define AXI_ID_BITS     4
`define AXI_ADDR_BITS   16
`define AXI_DATA_BITS   32
`define AXI_STRB_BITS   4
`define AXI_LEN_BITS    4
`define AXI_SIZE_BITS   3

// Burst size for full 32-bit words
`define AXI_SIZE_WORD   3'b010

// Response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

// ==== hdl/axi_sram_ctrl.sv ====
`timescale 1ns/1ns

module axi_sram_ctrl (
    input  logic                                  clk,
    input  logic                                  rst,
    // AW
    input  sram_pkg::axi_addr_t                   aw,
    input  logic                                  aw_valid,
    output logic                                  aw_ready,
    // W
    input  sram_pkg::axi_w_t                      w,
    input  logic                                  w_valid,
    output logic                                  w_ready,
    // B
    output sram_pkg::axi_b_t                      b,
    output logic                                  b_valid,
    input  logic                                  b_ready,
    // AR
    input  sram_pkg::axi_addr_t                   ar,
    input  logic                                  ar_valid,
    output logic                                  ar_ready,
    // R
    output sram_pkg::axi_r_t                      r,
    output logic                                  r_valid,
    input  logic                                  r_ready,
    // Address generator
    output logic                                  start,
    output logic                                  step,
    output sram_pkg::axi_addr_t                   cmd,
    input  logic [sram_pkg::WORD_ADDR_BITS-1:0]   word_addr,
    input  logic                                  last,
    input  logic                                  out_of_range,
    // SRAM
    output sram_pkg::sram_req_t                   req,
    input  logic [sram_pkg::DATA_BITS-1:0]        rdata
);

    sram_pkg::ctrl_state_e state;
    sram_pkg::ctrl_state_e next_state;

    logic [sram_pkg::ID_BITS-1:0] id_q;
    logic                         err_q;
    logic                         r_last_q;
    logic                         r_oor_q;
    logic                         w_hs;
    logic                         issue_rd;

    assign w_hs = w_valid & w_ready;

    // Write wins when both address channels are valid
    assign cmd = aw_valid ? aw : ar;

    always_comb begin
        next_state = state;
        aw_ready   = 1'b0;
        ar_ready   = 1'b0;
        w_ready    = 1'b0;
        b_valid    = 1'b0;
        r_valid    = 1'b0;
        start      = 1'b0;
        issue_rd   = 1'b0;
        case (state)
            sram_pkg::IDLE: begin
                aw_ready = 1'b1;
                ar_ready = ~aw_valid;
                if (aw_valid) begin
                    start      = 1'b1;
                    next_state = sram_pkg::WRITE;
                end else if (ar_valid) begin
                    start      = 1'b1;
                    next_state = sram_pkg::RD_ISSUE;
                end
            end
            sram_pkg::WRITE: begin
                w_ready = 1'b1;
                if (w_valid && w.last) begin
                    next_state = sram_pkg::WRESP;
                end
            end
            sram_pkg::WRESP: begin
                b_valid = 1'b1;
                if (b_ready) begin
                    next_state = sram_pkg::IDLE;
                end
            end
            sram_pkg::RD_ISSUE: begin
                issue_rd   = 1'b1;
                next_state = sram_pkg::RD_DATA;
            end
            sram_pkg::RD_DATA: begin
                r_valid = 1'b1;
                if (r_ready) begin
                    if (r_last_q) begin
                        next_state = sram_pkg::IDLE;
                    end else begin
                        // Next beat's read goes out with this transfer
                        issue_rd = 1'b1;
                    end
                end
            end
            default: next_state = sram_pkg::IDLE;
        endcase
    end

    // Address moves on after every write beat and every read issue
    assign step = w_hs | issue_rd;

    always_comb begin
        req.cs    = w_hs | issue_rd;
        req.oe    = issue_rd;
        req.web   = (w_hs && !out_of_range) ? ~w.strb : '1;
        req.addr  = word_addr;
        req.wdata = w.data;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= sram_pkg::IDLE;
            err_q    <= 1'b0;
            r_last_q <= 1'b0;
            r_oor_q  <= 1'b0;
        end else begin
            state <= next_state;
            if (start) begin
                err_q <= 1'b0;
            end else if (w_hs && out_of_range) begin
                err_q <= 1'b1;
            end
            // Flags follow the beat whose read was just issued
            if (issue_rd) begin
                r_last_q <= last;
                r_oor_q  <= out_of_range;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            id_q <= cmd.id;
        end
    end

    always_comb begin
        b.id   = id_q;
        b.resp = err_q ? sram_pkg::SLVERR : sram_pkg::OKAY;
        r.id   = id_q;
        r.data = r_oor_q ? '0 : rdata;
        r.resp = r_oor_q ? sram_pkg::SLVERR : sram_pkg::OKAY;
        r.last = r_last_q;
    end

    a_r_hold: assert property (@(posedge clk) disable iff (!rst)
        r_valid && !r_ready |=> r_valid && $stable(r));

    a_rb_excl: assert property (@(posedge clk) disable iff (!rst)
        !(r_valid && b_valid));

endmodule

// ==== hdl/axi_sram_top.sv ====
`timescale 1ns/1ns

module axi_sram_top #(
    parameter int DEPTH_WORDS = 4096
) (
    input  logic                  clk,
    input  logic                  rst,
    input  sram_pkg::axi_addr_t   aw,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  sram_pkg::axi_w_t      w,
    input  logic                  w_valid,
    output logic                  w_ready,
    output sram_pkg::axi_b_t      b,
    output logic                  b_valid,
    input  logic                  b_ready,
    input  sram_pkg::axi_addr_t   ar,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output sram_pkg::axi_r_t      r,
    output logic                  r_valid,
    input  logic                  r_ready
);

    logic                                start;
    logic                                step;
    sram_pkg::axi_addr_t                 cmd;
    logic [sram_pkg::WORD_ADDR_BITS-1:0] word_addr;
    logic                                last;
    logic                                out_of_range;
    sram_pkg::sram_req_t                 req;
    logic [sram_pkg::DATA_BITS-1:0]      rdata;

    axi_sram_ctrl i_axi_sram_ctrl (
        .clk          (clk),
        .rst          (rst),
        .aw           (aw),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w            (w),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .ar           (ar),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .r            (r),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .start        (start),
        .step         (step),
        .cmd          (cmd),
        .word_addr    (word_addr),
        .last         (last),
        .out_of_range (out_of_range),
        .req          (req),
        .rdata        (rdata)
    );

    axi_burst_addr #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_axi_burst_addr (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .step         (step),
        .cmd          (cmd),
        .word_addr    (word_addr),
        .last         (last),
        .out_of_range (out_of_range)
    );

    sram_macro #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_sram_macro (
        .clk   (clk),
        .req   (req),
        .rdata (rdata)
    );

endmodule

// ==== hdl/sram_macro.sv ====
`timescale 1ns/1ns

module sram_macro #(
    parameter int DEPTH_WORDS = 4096
) (
    input  logic                             clk,
    input  sram_pkg::sram_req_t              req,
    output logic [sram_pkg::DATA_BITS-1:0]   rdata
);

    localparam int IDX_BITS = $clog2(DEPTH_WORDS);

    logic [sram_pkg::DATA_BITS-1:0] mem [DEPTH_WORDS];
    logic [IDX_BITS-1:0]            idx;

    // Upper address bits are range-checked by the controller
    assign idx = req.addr[IDX_BITS-1:0];

    // Byte-lane writes
    always_ff @(posedge clk) begin
        if (req.cs) begin
            for (int i = 0; i < sram_pkg::STRB_BITS; i++) begin
                if (!req.web[i]) begin
                    mem[idx][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

    // Output register holds between reads
    always_ff @(posedge clk) begin
        if (req.cs && req.oe) begin
            rdata <= mem[idx];
        end
    end

endmodule

// ==== hdl/sram_pkg.sv ====
`include "axi_defs.svh"

package sram_pkg;

    localparam int ID_BITS        = `AXI_ID_BITS;
    localparam int ADDR_BITS      = `AXI_ADDR_BITS;
    localparam int DATA_BITS      = `AXI_DATA_BITS;
    localparam int STRB_BITS      = `AXI_STRB_BITS;
    localparam int LEN_BITS       = `AXI_LEN_BITS;
    localparam int SIZE_BITS      = `AXI_SIZE_BITS;
    // Byte address minus the two lane bits
    localparam int WORD_ADDR_BITS = `AXI_ADDR_BITS - 2;
    localparam logic [SIZE_BITS-1:0] SIZE_WORD = `AXI_SIZE_WORD;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        OKAY   = `AXI_RESP_OKAY,
        SLVERR = `AXI_RESP_SLVERR
    } axi_resp_e;

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        WRESP,
        RD_ISSUE,
        RD_DATA
    } ctrl_state_e;

    // Shared by AW and AR
    typedef struct packed {
        logic [ID_BITS-1:0]   id;
        logic [ADDR_BITS-1:0] addr;
        logic [LEN_BITS-1:0]  len;
        logic [SIZE_BITS-1:0] size;
        axi_burst_e           burst;
    } axi_addr_t;

    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic [STRB_BITS-1:0] strb;
        logic                 last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_BITS-1:0]   id;
        logic [DATA_BITS-1:0] data;
        axi_resp_e            resp;
        logic                 last;
    } axi_r_t;

    typedef struct packed {
        logic [ID_BITS-1:0] id;
        axi_resp_e          resp;
    } axi_b_t;

    // Byte write enables are active low
    typedef struct packed {
        logic                      cs;
        logic                      oe;
        logic [STRB_BITS-1:0]      web;
        logic [WORD_ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]      wdata;
    } sram_req_t;

endpackage

// ==== verification/axi_sram_cases.txt ====
# kind id byte_addr len burst(0 fixed, 1 incr, 2 wrap) wstrb resp(0 okay, 2 slverr), all hex
# kind W is a write, R a read, X a write and a read raised in the same cycle
W 1 0100 7 1 f 0
R 1 0100 7 1 0 0
W 2 0108 3 1 5 0
R 3 0100 7 1 0 0
W 4 0200 f 1 f 0
W 5 0218 7 2 f 0
R 6 0200 f 1 0 0
R 6 0218 7 2 0 0
W 7 0220 3 0 c 0
R 8 0200 f 1 0 0
R 8 0220 3 0 0 0
W 9 0000 f 1 f 0
R a 0000 f 1 0 0
W b 4000 3 1 f 2
R c 4000 3 1 0 2
R d 0000 f 1 0 0
W e fff0 1 2 f 2
X e 0400 3 1 f 0
X 3 0108 1 2 a 0

// ==== verification/tb_axi_sram.sv ====
`timescale 1ns/1ns

module tb_axi_sram;

    localparam int DEPTH_WORDS = 4096;
    localparam int MAX_CASES   = 64;

    typedef struct packed {
        logic [7:0]  kind;
        logic [3:0]  id;
        logic [15:0] addr;
        logic [3:0]  len;
        logic [1:0]  burst;
        logic [3:0]  strb;
        logic [1:0]  resp;
    } case_t;

    logic                clk;
    logic                rst;
    sram_pkg::axi_addr_t aw;
    logic                aw_valid;
    logic                aw_ready;
    sram_pkg::axi_w_t    w;
    logic                w_valid;
    logic                w_ready;
    sram_pkg::axi_b_t    b;
    logic                b_valid;
    logic                b_ready;
    sram_pkg::axi_addr_t ar;
    logic                ar_valid;
    logic                ar_ready;
    sram_pkg::axi_r_t    r;
    logic                r_valid;
    logic                r_ready;

    logic [31:0] shadow [DEPTH_WORDS];
    logic [31:0] lfsr;
    int          n_cases;
    case_t       cases [MAX_CASES];

    axi_sram_top #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) i_axi_sram_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hb4bcd35c;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    // Wrap stays inside an aligned block of len+1 words
    function automatic logic [13:0] next_word(input logic [13:0] a, input logic [3:0] len,
                                              input logic [1:0] burst);
        int span;
        int base;
        span = int'(len) + 1;
        base = int'(a) - (int'(a) % span);
        case (burst)
            2'd0:    return a;
            2'd2:    return 14'(base + (int'(a) - base + 1) % span);
            default: return a + 14'd1;
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h exp %h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic run_write(input case_t c);
        logic [13:0] wa;
        logic        done;
        aw       = {c.id, c.addr, c.len, 3'b010, c.burst};
        aw_valid = 1'b1;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            // A pending write keeps AR blocked
            check("ar_ready", ar_ready, 1'b0);
            check("rvalid", r_valid, 1'b0);
            done = aw_ready;
            next_cycle();
        end
        aw_valid = 1'b0;
        wa       = c.addr[15:2];
        for (int beat = 0; beat <= c.len; beat++) begin
            w.data  = rand_bits(32);
            w.strb  = c.strb;
            w.last  = (beat == c.len);
            w_valid = 1'b1;
            done    = 1'b0;
            while (!done) begin
                @(negedge clk);
                check("rvalid", r_valid, 1'b0);
                done = w_ready;
                next_cycle();
            end
            for (int i = 0; i < 4; i++) begin
                if (w.strb[i] && wa < DEPTH_WORDS) begin
                    shadow[wa][8*i +: 8] = w.data[8*i +: 8];
                end
            end
            wa = next_word(wa, c.len, c.burst);
        end
        w_valid = 1'b0;
        done    = 1'b0;
        while (!done) begin
            b_ready = rand_bits(1);
            @(negedge clk);
            // No R beat may come before the B response
            check("rvalid", r_valid, 1'b0);
            done = b_valid && b_ready;
            if (done) begin
                check("bid", b.id, c.id);
                check("bresp", b.resp, c.resp);
            end
            next_cycle();
        end
        b_ready = 1'b0;
    endtask

    task automatic run_read(input case_t c);
        logic [13:0] wa;
        logic        done;
        int          beat;
        ar       = {c.id, c.addr, c.len, 3'b010, c.burst};
        ar_valid = 1'b1;
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = ar_ready;
            next_cycle();
        end
        ar_valid = 1'b0;
        wa       = c.addr[15:2];
        beat     = 0;
        while (beat <= c.len) begin
            r_ready = rand_bits(1);
            @(negedge clk);
            if (r_valid && r_ready) begin
                check("rid", r.id, c.id);
                check("rdata", r.data, (wa < DEPTH_WORDS) ? shadow[wa] : 32'h0);
                check("rresp", r.resp, c.resp);
                check("rlast", r.last, beat == c.len);
                wa = next_word(wa, c.len, c.burst);
                beat++;
            end
            next_cycle();
        end
        r_ready = 1'b0;
        // No extra beat after RLAST
        @(negedge clk);
        check("rvalid", r_valid, 1'b0);
        next_cycle();
    endtask

    task automatic load_cases;
        int          fd;
        int          code;
        logic [7:0]  kind;
        logic [15:0] id;
        logic [15:0] addr;
        logic [15:0] len;
        logic [15:0] burst;
        logic [15:0] strb;
        logic [15:0] resp;
        logic [1023:0] rest;
        fd = $fopen("verification/axi_sram_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/axi_sram_cases.txt");
            $display("sim failed");
            $fatal(1);
        end
        code = $fscanf(fd, " %c", kind);
        while (code == 1 && n_cases < MAX_CASES) begin
            if (kind == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h", id, addr, len, burst, strb, resp);
                cases[n_cases] = {kind, id[3:0], addr, len[3:0], burst[1:0], strb[3:0],
                                  resp[1:0]};
                n_cases++;
            end
            code = $fscanf(fd, " %c", kind);
        end
        $fclose(fd);
    endtask

    initial begin
        rst      = 1'b0;
        aw       = '0;
        aw_valid = 1'b0;
        w        = '0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        ar       = '0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        lfsr     = 32'hc46a;
        n_cases  = 0;
        load_cases();
        if (n_cases == 0) begin
            $display("case file holds no transactions");
            $display("sim failed");
            $fatal(1);
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        next_cycle();
        for (int k = 0; k < n_cases; k++) begin
            case (cases[k].kind)
                "W": run_write(cases[k]);
                "R": run_read(cases[k]);
                "X": begin
                    // AR raised with AW, so the read waits behind the write
                    ar       = {cases[k].id, cases[k].addr, cases[k].len, 3'b010,
                                cases[k].burst};
                    ar_valid = 1'b1;
                    run_write(cases[k]);
                    run_read(cases[k]);
                end
                default: begin
                    $display("unknown transaction kind in case %0d", k);
                    $display("sim failed");
                    $fatal(1);
                end
            endcase
        end
        $display("sim passed");
        $finish;
    end

    // Watchdog
    initial begin
        wait (n_cases > 0);
        repeat (200 * n_cases + 16) @(posedge clk);
        $display("run timed out after %0d cycles", 200 * n_cases + 16);
        $display("sim failed");
        $fatal(1);
    end

endmodule
